//--- ddr_burst_sys.f
ddr_app_pkg.sv
burst_pkg.sv
ddr_controller.sv
app_dispatch.sv
bank_store.sv
rd_merge.sv
ddr_burst_sys.sv
tb_checker.sv
tb_ddr_burst_sys.sv

//--- run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --top-module tb_ddr_burst_sys -f ddr_burst_sys.f -o sim_tb || exit 1
out=$(./obj_dir/sim_tb)
echo "$out"
echo "$out" | grep -q "^Test passed$" && exit 0 || exit 1

//--- tb_ddr_burst_sys.sv
`timescale 1ns/10ps

module tb_ddr_burst_sys;

	localparam int DATA_WIDTH = 64;
	localparam int ADDR_WIDTH = 16;
	localparam int BANK_COUNT = 2;
	localparam int BANK_DEPTH = 256;
	localparam int MEM_WORDS = BANK_COUNT * BANK_DEPTH;
	localparam int LW = burst_pkg::LEN_WIDTH;
	localparam int HALF_PERIOD = 50;
	localparam int DRIVE_DELAY = 10;
	localparam int NUM_TESTS = 14;

	// ------------------------------------------------------------------
	// stimulus table, one burst per row
	// ------------------------------------------------------------------

	localparam bit TBL_WRITE [NUM_TESTS] = '{
		1'b1, 1'b0, 1'b1, 1'b0, 1'b1, 1'b0, 1'b1,
		1'b0, 1'b1, 1'b0, 1'b1, 1'b0, 1'b1, 1'b0
	};
	localparam logic [ADDR_WIDTH-1:0] TBL_ADDR [NUM_TESTS] = '{
		16'h0000, 16'h0000, 16'h0008, 16'h0008, 16'h0040, 16'h0040, 16'h0108,
		16'h0108, 16'h0200, 16'h0200, 16'h0280, 16'h0200, 16'h0018, 16'h0000
	};
	// row 10 overwrites part of row 8, row 13 reads across rows 0, 2 and 12.
	localparam int TBL_LEN [NUM_TESTS] = '{
		1, 1, 2, 2, 7, 7, 7,
		7, 64, 64, 5, 64, 1, 4
	};

	logic clk;
	logic rst;
	logic rd_burst_req;
	logic wr_burst_req;
	logic [LW-1:0] rd_burst_len;
	logic [LW-1:0] wr_burst_len;
	logic [ADDR_WIDTH-1:0] rd_burst_addr;
	logic [ADDR_WIDTH-1:0] wr_burst_addr;
	logic [DATA_WIDTH-1:0] wr_burst_data;
	logic rd_burst_data_valid;
	logic wr_burst_data_req;
	logic [DATA_WIDTH-1:0] rd_burst_data;
	logic rd_burst_finish;
	logic wr_burst_finish;
	logic burst_finish;
	logic init_calib_complete;

	logic [DATA_WIDTH-1:0] ref_mem [MEM_WORDS];
	integer seed;
	int tb_errors;
	int chk_errors;
	int finish_count;
	bit aborted;

	ddr_burst_sys #(
		.DATA_WIDTH(DATA_WIDTH),
		.ADDR_WIDTH(ADDR_WIDTH),
		.BANK_COUNT(BANK_COUNT),
		.BANK_DEPTH(BANK_DEPTH)
	) dut0 (
		.clk(clk),
		.rst(rst),
		.rd_burst_req(rd_burst_req),
		.wr_burst_req(wr_burst_req),
		.rd_burst_len(rd_burst_len),
		.wr_burst_len(wr_burst_len),
		.rd_burst_addr(rd_burst_addr),
		.wr_burst_addr(wr_burst_addr),
		.wr_burst_data(wr_burst_data),
		.rd_burst_data_valid(rd_burst_data_valid),
		.wr_burst_data_req(wr_burst_data_req),
		.rd_burst_data(rd_burst_data),
		.rd_burst_finish(rd_burst_finish),
		.wr_burst_finish(wr_burst_finish),
		.burst_finish(burst_finish),
		.init_calib_complete(init_calib_complete)
	);

	tb_checker #(
		.DATA_WIDTH(DATA_WIDTH),
		.ADDR_WIDTH(ADDR_WIDTH),
		.MEM_WORDS(MEM_WORDS)
	) chk0 (
		.clk(clk),
		.rst(rst),
		.rd_burst_req(rd_burst_req),
		.wr_burst_req(wr_burst_req),
		.rd_burst_len(rd_burst_len),
		.wr_burst_len(wr_burst_len),
		.rd_burst_addr(rd_burst_addr),
		.wr_burst_addr(wr_burst_addr),
		.rd_burst_data_valid(rd_burst_data_valid),
		.rd_burst_data(rd_burst_data),
		.wr_burst_data_req(wr_burst_data_req),
		.rd_burst_finish(rd_burst_finish),
		.wr_burst_finish(wr_burst_finish),
		.burst_finish(burst_finish),
		.ref_mem(ref_mem),
		.error_count(chk_errors),
		.finish_count(finish_count)
	);

	initial begin
		clk = 1'b0;
		forever #HALF_PERIOD clk = ~clk;
	end

	function automatic int word_index(input logic [ADDR_WIDTH-1:0] addr);
		return (int'(addr) / ddr_app_pkg::ADDR_STEP) % MEM_WORDS;
	endfunction

	// address in the low half, scrambled by a random upper half.
	function automatic logic [DATA_WIDTH-1:0] write_word(input logic [ADDR_WIDTH-1:0] addr);
		logic [31:0] rnd;
		rnd = $random(seed);
		return {rnd ^ {addr, addr}, ~addr, addr};
	endfunction

	task automatic expect_low(input string name, input logic value, input string phase);
		if (value !== 1'b0) begin
			$display("Mismatch %s %s: got %h expected 0", name, phase, value);
			tb_errors++;
		end
	endtask

	task automatic check_idle_outputs(input string phase);
		expect_low("wr_burst_data_req", wr_burst_data_req, phase);
		expect_low("rd_burst_data_valid", rd_burst_data_valid, phase);
		expect_low("rd_burst_finish", rd_burst_finish, phase);
		expect_low("wr_burst_finish", wr_burst_finish, phase);
		expect_low("burst_finish", burst_finish, phase);
		expect_low("init_calib_complete", init_calib_complete, phase);
	endtask

	task automatic wait_calibration();
		int cycles;
		cycles = 0;
		while (init_calib_complete !== 1'b1 && cycles < 4 * ddr_app_pkg::CALIB_CYCLES) begin
			check_idle_outputs("during calibration");
			@(posedge clk);
			#DRIVE_DELAY;
			cycles++;
		end
		if (init_calib_complete !== 1'b1) begin
			$display("timeout: init_calib_complete did not rise within %0d cycles", cycles);
			tb_errors++;
			aborted = 1'b1;
		end else if (cycles != ddr_app_pkg::CALIB_CYCLES) begin
			$display("calibration took %0d cycles, expected %0d",
				cycles, ddr_app_pkg::CALIB_CYCLES);
			tb_errors++;
		end
	endtask

	task automatic start_request(input int idx);
		if (TBL_WRITE[idx]) begin
			wr_burst_addr = TBL_ADDR[idx];
			wr_burst_len = LW'(TBL_LEN[idx]);
			wr_burst_data = write_word(TBL_ADDR[idx]);
			wr_burst_req = 1'b1;
		end else begin
			rd_burst_addr = TBL_ADDR[idx];
			rd_burst_len = LW'(TBL_LEN[idx]);
			rd_burst_req = 1'b1;
		end
	endtask

	// ------------------------------------------------------------------
	// burst driver
	// ------------------------------------------------------------------

	task automatic drive_until_finish(input int idx);
		int waited;
		int beat;
		int limit;
		logic taken;
		logic [ADDR_WIDTH-1:0] beat_addr;
		waited = 0;
		beat = 0;
		limit = 100 + 8 * TBL_LEN[idx];
		taken = wr_burst_data_req;
		while (burst_finish !== 1'b1 && waited < limit) begin
			@(posedge clk);
			#DRIVE_DELAY;
			waited++;
			// the beat shown last cycle went in at this edge.
			if (TBL_WRITE[idx] && taken === 1'b1 && beat < TBL_LEN[idx]) begin
				beat_addr = TBL_ADDR[idx] + ADDR_WIDTH'(beat * ddr_app_pkg::ADDR_STEP);
				ref_mem[word_index(beat_addr)] = wr_burst_data;
				beat++;
				wr_burst_data = write_word(beat_addr + ADDR_WIDTH'(ddr_app_pkg::ADDR_STEP));
			end
			taken = wr_burst_data_req;
		end
		if (burst_finish !== 1'b1) begin
			$display("timeout: burst %0d (%s at %h, %0d beats) did not finish in %0d cycles",
				idx, TBL_WRITE[idx] ? "write" : "read", TBL_ADDR[idx], TBL_LEN[idx], limit);
			tb_errors++;
			aborted = 1'b1;
		end else begin
			// request stays up through the finish cycle.
			@(posedge clk);
			#DRIVE_DELAY;
		end
		rd_burst_req = 1'b0;
		wr_burst_req = 1'b0;
	endtask

	initial begin
		rst = 1'b1;
		rd_burst_req = 1'b0;
		wr_burst_req = 1'b0;
		rd_burst_len = '0;
		wr_burst_len = '0;
		rd_burst_addr = '0;
		wr_burst_addr = '0;
		wr_burst_data = '0;
		seed = 32'hf5ce0d94;
		tb_errors = 0;
		aborted = 1'b0;
		repeat (8) begin
			@(posedge clk);
			#DRIVE_DELAY;
			check_idle_outputs("in reset");
		end
		rst = 1'b0;
		// first write waits for calibration.
		start_request(0);
		wait_calibration();
		for (int i = 0; i < NUM_TESTS; i++) begin
			if (!aborted) begin
				if (i > 0) begin
					start_request(i);
				end
				drive_until_finish(i);
			end
		end
		repeat (2) @(posedge clk);
		if (!aborted && finish_count != NUM_TESTS) begin
			$display("saw %0d finish pulses for %0d bursts", finish_count, NUM_TESTS);
			tb_errors++;
		end
		$display("tests %0d, finish pulses %0d, errors %0d",
			NUM_TESTS, finish_count, tb_errors + chk_errors);
		if (tb_errors + chk_errors == 0) begin
			$display("Test passed");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

//--- tb_checker.sv
`timescale 1ns/10ps

module tb_checker #(
	parameter int DATA_WIDTH = 64,
	parameter int ADDR_WIDTH = 16,
	parameter int MEM_WORDS = 512
) (
	input  logic                            clk,
	input  logic                            rst,
	input  logic                            rd_burst_req,
	input  logic                            wr_burst_req,
	input  logic [burst_pkg::LEN_WIDTH-1:0] rd_burst_len,
	input  logic [burst_pkg::LEN_WIDTH-1:0] wr_burst_len,
	input  logic [ADDR_WIDTH-1:0]           rd_burst_addr,
	input  logic [ADDR_WIDTH-1:0]           wr_burst_addr,
	input  logic                            rd_burst_data_valid,
	input  logic [DATA_WIDTH-1:0]           rd_burst_data,
	input  logic                            wr_burst_data_req,
	input  logic                            rd_burst_finish,
	input  logic                            wr_burst_finish,
	input  logic                            burst_finish,
	input  logic [DATA_WIDTH-1:0]           ref_mem [MEM_WORDS],
	output int                              error_count,
	output int                              finish_count
);

	int rd_beat;
	int wr_beat;
	int burst_errors;
	int exp_idx;
	logic prev_valid;

	task automatic count_error();
		burst_errors++;
		error_count++;
	endtask

	task automatic close_burst();
		rd_beat = 0;
		wr_beat = 0;
		burst_errors = 0;
		finish_count++;
	endtask

	task automatic check_read_end();
		if (rd_burst_req !== 1'b1 || wr_burst_finish === 1'b1) begin
			$display("read finish pulse with no read burst in progress");
			count_error();
		end
		if (rd_beat != int'(rd_burst_len)) begin
			$display("read burst returned %0d beats, expected %0d", rd_beat, rd_burst_len);
			count_error();
		end
		if (wr_beat != 0) begin
			$display("write data requested %0d times during a read burst", wr_beat);
			count_error();
		end
		if (prev_valid !== 1'b1) begin
			$display("read finish did not come one cycle after the last beat");
			count_error();
		end
		$display("burst %0d read  addr %h len %0d: %0d errors",
			finish_count, rd_burst_addr, rd_burst_len, burst_errors);
		close_burst();
	endtask

	task automatic check_write_end();
		if (wr_burst_req !== 1'b1) begin
			$display("write finish pulse with no write burst in progress");
			count_error();
		end
		if (wr_beat != int'(wr_burst_len)) begin
			$display("write burst took %0d beats, expected %0d", wr_beat, wr_burst_len);
			count_error();
		end
		if (rd_beat != 0) begin
			$display("%0d read beats returned during a write burst", rd_beat);
			count_error();
		end
		$display("burst %0d write addr %h len %0d: %0d errors",
			finish_count, wr_burst_addr, wr_burst_len, burst_errors);
		close_burst();
	endtask

	// ------------------------------------------------------------------
	// mid-cycle sampling of the DUT ports
	// ------------------------------------------------------------------

	always @(negedge clk) begin
		if (rst) begin
			rd_beat = 0;
			wr_beat = 0;
			burst_errors = 0;
			error_count = 0;
			finish_count = 0;
			prev_valid = 1'b0;
		end else begin
			// beats come back in address order.
			if (rd_burst_data_valid === 1'b1) begin
				exp_idx = (int'(rd_burst_addr) / ddr_app_pkg::ADDR_STEP + rd_beat) % MEM_WORDS;
				if (rd_burst_data !== ref_mem[exp_idx]) begin
					$display("Mismatch rd_burst_data beat %0d addr %h: got %h expected %h",
						rd_beat, rd_burst_addr + ADDR_WIDTH'(rd_beat * ddr_app_pkg::ADDR_STEP),
						rd_burst_data, ref_mem[exp_idx]);
					count_error();
				end
				rd_beat++;
			end
			if (wr_burst_data_req === 1'b1) begin
				wr_beat++;
			end
			if (burst_finish !== (rd_burst_finish | wr_burst_finish)) begin
				$display("Mismatch burst_finish: got %h expected %h",
					burst_finish, rd_burst_finish | wr_burst_finish);
				count_error();
			end
			if (rd_burst_finish === 1'b1) begin
				check_read_end();
			end else if (wr_burst_finish === 1'b1) begin
				check_write_end();
			end
			prev_valid = rd_burst_data_valid;
		end
	end

endmodule

//--- ddr_burst_sys.sv
`timescale 1ns/10ps

module ddr_burst_sys #(
	parameter int DATA_WIDTH = 64,
	parameter int ADDR_WIDTH = 16,
	parameter int BANK_COUNT = 2,
	parameter int BANK_DEPTH = 256
) (
	input  logic                            clk,
	input  logic                            rst,
	input  logic                            rd_burst_req,
	input  logic                            wr_burst_req,
	input  logic [burst_pkg::LEN_WIDTH-1:0] rd_burst_len,
	input  logic [burst_pkg::LEN_WIDTH-1:0] wr_burst_len,
	input  logic [ADDR_WIDTH-1:0]           rd_burst_addr,
	input  logic [ADDR_WIDTH-1:0]           wr_burst_addr,
	input  logic [DATA_WIDTH-1:0]           wr_burst_data,
	output logic                            rd_burst_data_valid,
	output logic                            wr_burst_data_req,
	output logic [DATA_WIDTH-1:0]           rd_burst_data,
	output logic                            rd_burst_finish,
	output logic                            wr_burst_finish,
	output logic                            burst_finish,
	output logic                            init_calib_complete
);

	// application interface.
	logic [ADDR_WIDTH-1:0] app_addr;
	logic [2:0] app_cmd;
	logic app_en;
	logic app_rdy;
	logic [DATA_WIDTH-1:0] app_wdf_data;
	logic app_wdf_end;
	logic app_wdf_wren;
	logic app_wdf_rdy;
	logic [DATA_WIDTH-1:0] app_rd_data;
	logic app_rd_data_valid;

	// bank side.
	logic [BANK_COUNT-1:0] bank_access;
	logic bank_write;
	logic [$clog2(BANK_DEPTH)-1:0] bank_row;
	logic [DATA_WIDTH-1:0] bank_wdata;
	logic [BANK_COUNT-1:0] bank_busy;
	logic [BANK_COUNT-1:0] bank_rd_valid;
	logic [BANK_COUNT*DATA_WIDTH-1:0] bank_rd_data;

	// debug outputs and the write mask stay open here.
	ddr_controller #(
		.DATA_WIDTH(DATA_WIDTH),
		.ADDR_WIDTH(ADDR_WIDTH)
	) ctrl0 (
		.clk(clk),
		.rst(rst),
		.rd_burst_req(rd_burst_req),
		.wr_burst_req(wr_burst_req),
		.rd_burst_len(rd_burst_len),
		.wr_burst_len(wr_burst_len),
		.rd_burst_addr(rd_burst_addr),
		.wr_burst_addr(wr_burst_addr),
		.wr_burst_data(wr_burst_data),
		.app_rd_data(app_rd_data),
		.app_rd_data_valid(app_rd_data_valid),
		.app_rdy(app_rdy),
		.app_wdf_rdy(app_wdf_rdy),
		.init_calib_complete(init_calib_complete),
		.rd_burst_data_valid(rd_burst_data_valid),
		.rd_burst_data_valid_delay(),
		.wr_burst_data_req(wr_burst_data_req),
		.rd_burst_data(rd_burst_data),
		.rd_burst_finish(rd_burst_finish),
		.wr_burst_finish(wr_burst_finish),
		.burst_finish(burst_finish),
		.rd_addr_cnt(),
		.app_addr(app_addr),
		.app_cmd(app_cmd),
		.app_en(app_en),
		.app_wdf_data(app_wdf_data),
		.app_wdf_end(app_wdf_end),
		.app_wdf_mask(),
		.app_wdf_wren(app_wdf_wren)
	);

	app_dispatch #(
		.DATA_WIDTH(DATA_WIDTH),
		.ADDR_WIDTH(ADDR_WIDTH),
		.BANK_COUNT(BANK_COUNT),
		.BANK_DEPTH(BANK_DEPTH)
	) disp0 (
		.clk(clk),
		.rst(rst),
		.app_addr(app_addr),
		.app_cmd(app_cmd),
		.app_en(app_en),
		.app_wdf_data(app_wdf_data),
		.app_wdf_end(app_wdf_end),
		.app_wdf_wren(app_wdf_wren),
		.bank_busy(bank_busy),
		.app_rdy(app_rdy),
		.app_wdf_rdy(app_wdf_rdy),
		.init_calib_complete(init_calib_complete),
		.bank_access(bank_access),
		.bank_write(bank_write),
		.bank_row(bank_row),
		.bank_wdata(bank_wdata)
	);

	// ------------------------------------------------------------------
	// interleaved banks
	// ------------------------------------------------------------------

	for (genvar b = 0; b < BANK_COUNT; b++) begin : g_bank
		bank_store #(
			.DATA_WIDTH(DATA_WIDTH),
			.BANK_DEPTH(BANK_DEPTH)
		) bank0 (
			.clk(clk),
			.rst(rst),
			.access(bank_access[b]),
			.write(bank_write),
			.row(bank_row),
			.wdata(bank_wdata),
			.busy(bank_busy[b]),
			.rd_valid(bank_rd_valid[b]),
			.rd_data(bank_rd_data[b*DATA_WIDTH +: DATA_WIDTH])
		);
	end

	rd_merge #(
		.DATA_WIDTH(DATA_WIDTH),
		.BANK_COUNT(BANK_COUNT)
	) merge0 (
		.clk(clk),
		.rst(rst),
		.bank_rd_valid(bank_rd_valid),
		.bank_rd_data(bank_rd_data),
		.app_rd_data_valid(app_rd_data_valid),
		.app_rd_data(app_rd_data)
	);

endmodule

//--- rd_merge.sv
`timescale 1ns/10ps

module rd_merge #(
	parameter int DATA_WIDTH = 64,
	parameter int BANK_COUNT = 2
) (
	input  logic                             clk,
	input  logic                             rst,
	input  logic [BANK_COUNT-1:0]            bank_rd_valid,
	input  logic [BANK_COUNT*DATA_WIDTH-1:0] bank_rd_data,
	output logic                             app_rd_data_valid,
	output logic [DATA_WIDTH-1:0]            app_rd_data
);

	logic [DATA_WIDTH-1:0] sel_data;

	// at most one bank is valid in any cycle.
	always_comb begin
		sel_data = '0;
		for (int i = 0; i < BANK_COUNT; i++) begin
			if (bank_rd_valid[i]) begin
				sel_data = bank_rd_data[i*DATA_WIDTH +: DATA_WIDTH];
			end
		end
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			app_rd_data_valid <= 1'b0;
		end else begin
			app_rd_data_valid <= |bank_rd_valid;
		end
	end

	always_ff @(posedge clk) begin
		app_rd_data <= sel_data;
	end

endmodule

//--- bank_store.sv
`timescale 1ns/10ps

module bank_store #(
	parameter int DATA_WIDTH = 64,
	parameter int BANK_DEPTH = 256
) (
	input  logic                          clk,
	input  logic                          rst,
	input  logic                          access,
	input  logic                          write,
	input  logic [$clog2(BANK_DEPTH)-1:0] row,
	input  logic [DATA_WIDTH-1:0]         wdata,
	output logic                          busy,
	output logic                          rd_valid,
	output logic [DATA_WIDTH-1:0]         rd_data
);

	localparam int LAT = ddr_app_pkg::RD_LATENCY;
	localparam int BUSY_W = $clog2(ddr_app_pkg::BANK_BUSY + 1);

	logic [DATA_WIDTH-1:0] mem [BANK_DEPTH];
	logic [LAT-1:0] vld_pipe;
	logic [DATA_WIDTH-1:0] data_pipe [LAT];
	logic [BUSY_W-1:0] busy_cnt;

	always_ff @(posedge clk) begin
		if (access && write) begin
			mem[row] <= wdata;
		end
	end

	// read delay line.
	always_ff @(posedge clk) begin
		data_pipe[0] <= mem[row];
		for (int i = 1; i < LAT; i++) begin
			data_pipe[i] <= data_pipe[i-1];
		end
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			vld_pipe <= '0;
		end else begin
			vld_pipe <= {vld_pipe[LAT-2:0], access & ~write};
		end
	end

	assign rd_valid = vld_pipe[LAT-1];
	assign rd_data = data_pipe[LAT-1];

	// holdoff after every access.
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			busy_cnt <= '0;
		end else if (access) begin
			busy_cnt <= BUSY_W'(ddr_app_pkg::BANK_BUSY);
		end else if (busy_cnt != '0) begin
			busy_cnt <= busy_cnt - 1'b1;
		end
	end

	assign busy = (busy_cnt != '0);

endmodule

//--- app_dispatch.sv
`timescale 1ns/10ps

module app_dispatch #(
	parameter int DATA_WIDTH = 64,
	parameter int ADDR_WIDTH = 16,
	parameter int BANK_COUNT = 2,
	parameter int BANK_DEPTH = 256
) (
	input  logic                          clk,
	input  logic                          rst,
	input  logic [ADDR_WIDTH-1:0]         app_addr,
	input  logic [2:0]                    app_cmd,
	input  logic                          app_en,
	input  logic [DATA_WIDTH-1:0]         app_wdf_data,
	input  logic                          app_wdf_end,
	input  logic                          app_wdf_wren,
	input  logic [BANK_COUNT-1:0]         bank_busy,
	output logic                          app_rdy,
	output logic                          app_wdf_rdy,
	output logic                          init_calib_complete,
	output logic [BANK_COUNT-1:0]         bank_access,
	output logic                          bank_write,
	output logic [$clog2(BANK_DEPTH)-1:0] bank_row,
	output logic [DATA_WIDTH-1:0]         bank_wdata
);

	localparam int STEP_SHIFT = $clog2(ddr_app_pkg::ADDR_STEP);
	localparam int BANK_BITS = $clog2(BANK_COUNT);
	localparam int ROW_BITS = $clog2(BANK_DEPTH);
	localparam int CALIB_W = $clog2(ddr_app_pkg::CALIB_CYCLES + 1);

	logic [CALIB_W-1:0] calib_cnt;
	logic [DATA_WIDTH-1:0] q_mem [4];
	logic [1:0] q_wr_ptr;
	logic [1:0] q_rd_ptr;
	logic [2:0] q_count;
	logic q_push;
	logic q_pop;
	logic [ADDR_WIDTH-STEP_SHIFT-1:0] beat_idx;
	logic [BANK_BITS-1:0] bank_sel;
	logic is_read;
	logic is_write;
	logic accept;

	// calibration delay.
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			calib_cnt <= '0;
			init_calib_complete <= 1'b0;
		end else if (!init_calib_complete) begin
			calib_cnt <= calib_cnt + 1'b1;
			if (calib_cnt == CALIB_W'(ddr_app_pkg::CALIB_CYCLES - 1)) begin
				init_calib_complete <= 1'b1;
			end
		end
	end

	// ------------------------------------------------------------------
	// command decode and acceptance
	// ------------------------------------------------------------------

	assign beat_idx = app_addr[ADDR_WIDTH-1:STEP_SHIFT];
	assign bank_sel = beat_idx[BANK_BITS-1:0];
	assign bank_row = beat_idx[BANK_BITS +: ROW_BITS];

	assign is_read = (app_cmd == ddr_app_pkg::CMD_READ);
	assign is_write = (app_cmd == ddr_app_pkg::CMD_WRITE);

	// a write needs its data already at the queue head.
	assign app_rdy = init_calib_complete & ~bank_busy[bank_sel] &
		(is_read | (is_write & (q_count != 3'd0)));
	assign accept = app_en & app_rdy;

	always_comb begin
		for (int i = 0; i < BANK_COUNT; i++) begin
			bank_access[i] = accept & (bank_sel == BANK_BITS'(i));
		end
	end

	assign bank_write = is_write;
	assign bank_wdata = q_mem[q_rd_ptr];

	// ------------------------------------------------------------------
	// write data queue, four entries
	// ------------------------------------------------------------------

	assign app_wdf_rdy = (q_count != 3'd4);
	assign q_push = app_wdf_wren & app_wdf_end & app_wdf_rdy;
	assign q_pop = accept & is_write;

	always_ff @(posedge clk) begin
		if (q_push) begin
			q_mem[q_wr_ptr] <= app_wdf_data;
		end
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			q_wr_ptr <= '0;
			q_rd_ptr <= '0;
			q_count <= '0;
		end else begin
			if (q_push) begin
				q_wr_ptr <= q_wr_ptr + 1'b1;
			end
			if (q_pop) begin
				q_rd_ptr <= q_rd_ptr + 1'b1;
			end
			if (q_push && !q_pop) begin
				q_count <= q_count + 1'b1;
			end else if (q_pop && !q_push) begin
				q_count <= q_count - 1'b1;
			end
		end
	end

endmodule

//--- ddr_controller.sv
`timescale 1ns/10ps

module ddr_controller #(
	parameter int DATA_WIDTH = 64,
	parameter int ADDR_WIDTH = 16
) (
	input  logic                            clk,
	input  logic                            rst,
	input  logic                            rd_burst_req,
	input  logic                            wr_burst_req,
	input  logic [burst_pkg::LEN_WIDTH-1:0] rd_burst_len,
	input  logic [burst_pkg::LEN_WIDTH-1:0] wr_burst_len,
	input  logic [ADDR_WIDTH-1:0]           rd_burst_addr,
	input  logic [ADDR_WIDTH-1:0]           wr_burst_addr,
	input  logic [DATA_WIDTH-1:0]           wr_burst_data,
	input  logic [DATA_WIDTH-1:0]           app_rd_data,
	input  logic                            app_rd_data_valid,
	input  logic                            app_rdy,
	input  logic                            app_wdf_rdy,
	input  logic                            init_calib_complete,
	output logic                            rd_burst_data_valid,
	output logic                            rd_burst_data_valid_delay,
	output logic                            wr_burst_data_req,
	output logic [DATA_WIDTH-1:0]           rd_burst_data,
	output logic                            rd_burst_finish,
	output logic                            wr_burst_finish,
	output logic                            burst_finish,
	output logic [burst_pkg::LEN_WIDTH-1:0] rd_addr_cnt,
	output logic [ADDR_WIDTH-1:0]           app_addr,
	output logic [2:0]                      app_cmd,
	output logic                            app_en,
	output logic [DATA_WIDTH-1:0]           app_wdf_data,
	output logic                            app_wdf_end,
	output logic [DATA_WIDTH/8-1:0]         app_wdf_mask,
	output logic                            app_wdf_wren
);

	localparam int LW = burst_pkg::LEN_WIDTH;

	typedef enum logic [2:0] {
		S_IDLE,
		S_READ,
		S_READ_WAIT,
		S_WRITE,
		S_WRITE_WAIT,
		S_READ_END,
		S_WRITE_END
	} state_t;

	state_t state;

	logic [LW-1:0] rd_data_cnt;
	logic [LW-1:0] wr_addr_cnt;
	logic [LW-1:0] wr_data_cnt;
	logic [ADDR_WIDTH-1:0] addr_next;
	logic cmd_taken;
	logic last_rd_cmd;
	logic last_rd_data;
	logic last_wr_cmd;
	logic last_wr_data;

	// ------------------------------------------------------------------
	// datapath and handshakes
	// ------------------------------------------------------------------

	assign app_wdf_mask = '0;
	assign app_wdf_data = wr_burst_data;

	// one write beat per burst word, so every beat is also its own end.
	assign wr_burst_data_req = (state == S_WRITE) & app_wdf_rdy;
	assign app_wdf_wren = wr_burst_data_req;
	assign app_wdf_end = app_wdf_wren;

	assign rd_burst_data = app_rd_data;
	assign rd_burst_data_valid = app_rd_data_valid;

	assign rd_burst_finish = (state == S_READ_END);
	assign wr_burst_finish = (state == S_WRITE_END);
	assign burst_finish = rd_burst_finish | wr_burst_finish;

	assign cmd_taken = app_en & app_rdy;
	assign addr_next = app_addr + ADDR_WIDTH'(ddr_app_pkg::ADDR_STEP);

	assign last_rd_cmd = (rd_addr_cnt == rd_burst_len - 1'b1);
	assign last_rd_data = (rd_data_cnt == rd_burst_len - 1'b1);
	assign last_wr_cmd = (wr_addr_cnt == wr_burst_len - 1'b1);
	assign last_wr_data = (wr_data_cnt == wr_burst_len - 1'b1);

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			rd_burst_data_valid_delay <= 1'b0;
		end else begin
			rd_burst_data_valid_delay <= app_rd_data_valid;
		end
	end

	// returned read beats, counted in both read states.
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			rd_data_cnt <= '0;
		end else if (app_rd_data_valid) begin
			if (last_rd_data) begin
				rd_data_cnt <= '0;
			end else begin
				rd_data_cnt <= rd_data_cnt + 1'b1;
			end
		end
	end

	// ------------------------------------------------------------------
	// burst FSM
	// ------------------------------------------------------------------

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state <= S_IDLE;
			app_cmd <= ddr_app_pkg::CMD_WRITE;
			app_addr <= '0;
			app_en <= 1'b0;
			rd_addr_cnt <= '0;
			wr_addr_cnt <= '0;
			wr_data_cnt <= '0;
		end else if (init_calib_complete) begin
			case (state)
				S_IDLE: begin
					if (rd_burst_req) begin
						state <= S_READ;
						app_cmd <= ddr_app_pkg::CMD_READ;
						app_addr <= rd_burst_addr;
						app_en <= 1'b1;
						rd_addr_cnt <= '0;
					end else if (wr_burst_req) begin
						state <= S_WRITE;
						app_cmd <= ddr_app_pkg::CMD_WRITE;
						app_addr <= wr_burst_addr;
						app_en <= 1'b1;
						wr_addr_cnt <= '0;
						wr_data_cnt <= '0;
					end
				end
				S_READ: begin
					if (cmd_taken) begin
						app_addr <= addr_next;
						if (last_rd_cmd) begin
							state <= S_READ_WAIT;
							app_en <= 1'b0;
							rd_addr_cnt <= '0;
						end else begin
							rd_addr_cnt <= rd_addr_cnt + 1'b1;
						end
					end
					if (app_rd_data_valid && last_rd_data) begin
						state <= S_READ_END;
					end
				end
				S_READ_WAIT: begin
					if (app_rd_data_valid && last_rd_data) begin
						state <= S_READ_END;
					end
				end
				S_WRITE: begin
					if (cmd_taken) begin
						app_addr <= addr_next;
						if (last_wr_cmd) begin
							app_en <= 1'b0;
						end else begin
							wr_addr_cnt <= wr_addr_cnt + 1'b1;
						end
					end
					if (wr_burst_data_req) begin
						if (last_wr_data) begin
							state <= S_WRITE_WAIT;
						end else begin
							wr_data_cnt <= wr_data_cnt + 1'b1;
						end
					end
				end
				S_WRITE_WAIT: begin
					// commands trail the data, so drain them here.
					if (cmd_taken) begin
						app_addr <= addr_next;
						if (last_wr_cmd) begin
							app_en <= 1'b0;
							state <= S_WRITE_END;
						end else begin
							wr_addr_cnt <= wr_addr_cnt + 1'b1;
						end
					end else if (!app_en) begin
						state <= S_WRITE_END;
					end
				end
				S_READ_END: begin
					state <= S_IDLE;
				end
				S_WRITE_END: begin
					state <= S_IDLE;
					wr_addr_cnt <= '0;
					wr_data_cnt <= '0;
				end
				default: begin
					state <= S_IDLE;
				end
			endcase
		end
	end

endmodule

//--- burst_pkg.sv
package burst_pkg;

	// ------------------------------------------------------------------
	// client burst interface
	// ------------------------------------------------------------------

	// burst length in beats, 1 to 1023.
	localparam int LEN_WIDTH = 10;

endpackage

//--- ddr_app_pkg.sv
package ddr_app_pkg;

	// ------------------------------------------------------------------
	// application interface command codes
	// ------------------------------------------------------------------

	localparam logic [2:0] CMD_WRITE = 3'd0;
	localparam logic [2:0] CMD_READ = 3'd1;

	// byte address advance for one beat.
	localparam int ADDR_STEP = 8;

	// ------------------------------------------------------------------
	// behavioural memory timing
	// ------------------------------------------------------------------

	// cycles from bank strobe to bank read output.
	localparam int RD_LATENCY = 2;

	// bank refuses a new access this many cycles after one.
	localparam int BANK_BUSY = 2;

	// cycles after reset release until calibration reports done.
	localparam int CALIB_CYCLES = 16;

endpackage
